//--- Makefile
# Verilator build and run for the result-return path testbench

VERILATOR ?= verilator
TOP       ?= tb_vcop_result
FILELIST  ?= vcop_result_top.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- logic/vcop_csr_unit.sv
/*
 * CSR unit: vector-length register with swap access and a counter of
 * retired results, passing requests straight to the result buffer
 */
`timescale 1ns/1ps

module vcop_csr_unit (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] req_id_i,
    input  logic [4:0]                req_rd_i,
    input  vcop_pkg::op_e             req_op_i,
    input  logic [31:0]               req_src_i,
    input  logic                      retire_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output logic [vcop_pkg::ID_W-1:0] res_id_o,
    output logic [4:0]                res_rd_o,
    output logic                      res_delayed_o,
    output logic [31:0]               res_data_o,
    output logic [31:0]               res_delayed_data_o
);

    logic [31:0] vl_q;
    logic [31:0] retired_q;
    logic        is_retired_read;

    assign is_retired_read = (req_op_i == vcop_pkg::OP_CSRR_RETIRED);

    // Request goes through to the arbiter buffer in the same cycle
    assign req_ready_o   = res_ready_i;
    assign res_valid_o   = req_valid_i;
    assign res_id_o      = req_id_i;
    assign res_rd_o      = req_rd_i;
    assign res_delayed_o = is_retired_read;
    assign res_data_o    = is_retired_read ? 32'd0 : vl_q;

    // Counter value is sampled by the arbiter when the result is sent
    assign res_delayed_data_o = retired_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vl_q      <= '0;
            retired_q <= '0;
        end else begin
            if (req_valid_i && req_ready_o && req_op_i == vcop_pkg::OP_CSRRW_VL) begin
                vl_q <= req_src_i;
            end
            if (retire_i) begin
                retired_q <= retired_q + 32'd1;
            end
        end
    end

endmodule

//--- logic/vcop_dispatch.sv
/*
 * Dispatch stage: decodes issued instructions, tracks in-flight IDs
 * and routes each instruction to its result producer
 */
`timescale 1ns/1ps

module vcop_dispatch (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] issue_id_i,
    input  vcop_pkg::op_e             issue_op_i,
    input  logic                      retire_i,
    input  logic [vcop_pkg::ID_W-1:0] retire_id_i,
    output logic                      lsu_valid_o,
    input  logic                      lsu_ready_i,
    output logic                      popc_valid_o,
    input  logic                      popc_ready_i,
    output logic                      csr_valid_o,
    input  logic                      csr_ready_i,
    output logic                      empty_valid_o
);

    logic [vcop_pkg::ID_CNT-1:0] inflight_q;
    logic to_lsu, to_popc, to_csr, to_empty;
    logic id_free, target_ready;

    always_comb begin
        to_lsu   = 1'b0;
        to_popc  = 1'b0;
        to_csr   = 1'b0;
        to_empty = 1'b0;
        case (issue_op_i)
            vcop_pkg::OP_LOAD:         to_lsu  = 1'b1;
            vcop_pkg::OP_POPC:         to_popc = 1'b1;
            vcop_pkg::OP_CSRRW_VL,
            vcop_pkg::OP_CSRR_RETIRED: to_csr  = 1'b1;
            // Undefined opcodes only return an empty result
            default:                   to_empty = 1'b1;
        endcase
    end

    assign id_free       = ~inflight_q[issue_id_i];
    assign target_ready  = (to_lsu & lsu_ready_i) | (to_popc & popc_ready_i)
                         | (to_csr & csr_ready_i) | to_empty;
    assign issue_ready_o = id_free & target_ready;

    assign lsu_valid_o   = issue_valid_i & id_free & to_lsu;
    assign popc_valid_o  = issue_valid_i & id_free & to_popc;
    assign csr_valid_o   = issue_valid_i & id_free & to_csr;
    assign empty_valid_o = issue_valid_i & id_free & to_empty;

    // An empty result may retire in its issue cycle, so clear wins over set
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            inflight_q <= '0;
        end else begin
            if (issue_valid_i && issue_ready_o) begin
                inflight_q[issue_id_i] <= 1'b1;
            end
            if (retire_i) begin
                inflight_q[retire_id_i] <= 1'b0;
            end
        end
    end

    a_one_destination: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $onehot0({lsu_valid_o, popc_valid_o, csr_valid_o, empty_valid_o}));

endmodule

//--- logic/vcop_lsu_check.sv
/*
 * Load address checker: one register stage that flags misaligned
 * addresses and returns an exception or a clean result
 */
`timescale 1ns/1ps

module vcop_lsu_check (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] req_id_i,
    input  logic [31:0]               req_addr_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output logic [vcop_pkg::ID_W-1:0] res_id_o,
    output logic                      res_exc_o,
    output logic [5:0]                res_exccode_o
);

    logic                      valid_q;
    logic [vcop_pkg::ID_W-1:0] id_q;
    logic                      exc_q;

    // Free when empty or when the held result leaves this cycle
    assign req_ready_o = ~valid_q | res_ready_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else if (req_ready_o) begin
            valid_q <= req_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            id_q  <= req_id_i;
            exc_q <= |req_addr_i[1:0];
        end
    end

    assign res_valid_o   = valid_q;
    assign res_id_o      = id_q;
    assign res_exc_o     = exc_q;
    assign res_exccode_o = exc_q ? vcop_pkg::EXC_LOAD_MISALIGNED : 6'd0;

endmodule

//--- logic/vcop_pkg.sv
/*
 * Vector coprocessor shared definitions for the result-return path
 */
package vcop_pkg;

    // Instruction ID space shared with the scalar core
    localparam int unsigned ID_W   = 3;
    localparam int unsigned ID_CNT = 1 << ID_W;

    typedef enum logic [2:0] {
        OP_EMPTY,
        OP_LOAD,
        OP_POPC,
        OP_CSRRW_VL,
        OP_CSRR_RETIRED
    } op_e;

    // Exception code reported for a misaligned load address
    localparam logic [5:0] EXC_LOAD_MISALIGNED = 6'd4;

    typedef struct packed {
        logic [25:0] pad;
        logic [5:0]  exccode;
    } result_exc_t;

    // Result word carries register data or an exception record
    typedef union packed {
        logic [31:0] data;
        result_exc_t exc;
    } result_payload_u;

endpackage

//--- logic/vcop_popc_pipe.sv
/*
 * Scalar-move pipeline: two stallable stages computing the population
 * count of a source operand for a scalar register write
 */
`timescale 1ns/1ps

module vcop_popc_pipe (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] req_id_i,
    input  logic [4:0]                req_rd_i,
    input  logic [31:0]               req_src_i,
    output logic                      res_valid_o,
    input  logic                      res_ready_i,
    output logic [vcop_pkg::ID_W-1:0] res_id_o,
    output logic [4:0]                res_rd_o,
    output logic [31:0]               res_data_o
);

    logic                      s1_valid_q, s2_valid_q;
    logic [vcop_pkg::ID_W-1:0] s1_id_q, s2_id_q;
    logic [4:0]                s1_rd_q, s2_rd_q;
    logic [4:0]                s1_lo_q, s1_hi_q;
    logic [31:0]               s2_data_q;
    logic                      s1_en, s2_en;

    function automatic logic [4:0] count_half(input logic [15:0] v);
        logic [4:0] n;
        n = '0;
        for (int i = 0; i < 16; i++) begin
            n = n + {4'b0, v[i]};
        end
        return n;
    endfunction

    // Each stage moves when the stage after it is free
    assign s2_en       = ~s2_valid_q | res_ready_i;
    assign s1_en       = ~s1_valid_q | s2_en;
    assign req_ready_o = s1_en;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
        end else begin
            if (s1_en) begin
                s1_valid_q <= req_valid_i;
            end
            if (s2_en) begin
                s2_valid_q <= s1_valid_q;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (s1_en && req_valid_i) begin
            s1_id_q <= req_id_i;
            s1_rd_q <= req_rd_i;
            s1_lo_q <= count_half(req_src_i[15:0]);
            s1_hi_q <= count_half(req_src_i[31:16]);
        end
        if (s2_en && s1_valid_q) begin
            s2_id_q   <= s1_id_q;
            s2_rd_q   <= s1_rd_q;
            s2_data_q <= {27'b0, s1_lo_q} + {27'b0, s1_hi_q};
        end
    end

    assign res_valid_o = s2_valid_q;
    assign res_id_o    = s2_id_q;
    assign res_rd_o    = s2_rd_q;
    assign res_data_o  = s2_data_q;

endmodule

//--- logic/vcop_result_arbiter.sv
/*
 * Result arbiter: merges producer results onto one result port by fixed
 * priority, buffering empty results by ID and the CSR result
 */
`timescale 1ns/1ps

module vcop_result_arbiter (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      empty_valid_i,
    input  logic [vcop_pkg::ID_W-1:0] empty_id_i,
    input  logic                      lsu_valid_i,
    output logic                      lsu_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] lsu_id_i,
    input  logic                      lsu_exc_i,
    input  logic [5:0]                lsu_exccode_i,
    input  logic                      xreg_valid_i,
    output logic                      xreg_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] xreg_id_i,
    input  logic [4:0]                xreg_rd_i,
    input  logic [31:0]               xreg_data_i,
    input  logic                      csr_valid_i,
    output logic                      csr_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] csr_id_i,
    input  logic [4:0]                csr_rd_i,
    input  logic                      csr_delayed_i,
    input  logic [31:0]               csr_data_i,
    input  logic [31:0]               csr_delayed_data_i,
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    output logic [vcop_pkg::ID_W-1:0] result_id_o,
    output vcop_pkg::result_payload_u result_payload_o,
    output logic [4:0]                result_rd_o,
    output logic                      result_we_o,
    output logic                      result_exc_o
);

    logic [vcop_pkg::ID_CNT-1:0] empty_q, empty_d;
    logic                        csr_valid_q, csr_delayed_q;
    logic [vcop_pkg::ID_W-1:0]   csr_id_q, ebuf_low_id, ebuf_id, hold_eid_q;
    logic [4:0]                  csr_rd_q;
    logic [31:0]                 csr_data_q;
    logic                        ebuf_found, hold_q;
    logic [3:0]                  hold_src_q;
    logic sel_lsu, sel_xreg, sel_csr, sel_ebuf, sel_empty;

    // Lowest buffered empty ID
    always_comb begin
        ebuf_found  = 1'b0;
        ebuf_low_id = '0;
        for (int i = 0; i < vcop_pkg::ID_CNT; i++) begin
            if (empty_q[i] && !ebuf_found) begin
                ebuf_found  = 1'b1;
                ebuf_low_id = i[vcop_pkg::ID_W-1:0];
            end
        end
    end

    // A stalled result keeps its source, so later arrivals cannot preempt it
    always_comb begin
        {sel_lsu, sel_xreg, sel_csr, sel_ebuf, sel_empty} = '0;
        if (hold_q) begin
            {sel_lsu, sel_xreg, sel_csr, sel_ebuf} = hold_src_q;
        end else if (lsu_valid_i) begin
            sel_lsu = 1'b1;
        end else if (xreg_valid_i) begin
            sel_xreg = 1'b1;
        end else if (csr_valid_q) begin
            sel_csr = 1'b1;
        end else if (ebuf_found) begin
            sel_ebuf = 1'b1;
        end else if (empty_valid_i) begin
            sel_empty = 1'b1;
        end
    end

    assign ebuf_id      = hold_q ? hold_eid_q : ebuf_low_id;
    assign lsu_ready_o  = sel_lsu & result_ready_i;
    assign xreg_ready_o = sel_xreg & result_ready_i;
    assign csr_ready_o  = ~csr_valid_q | (sel_csr & result_ready_i);

    always_comb begin
        empty_d = empty_q;
        if (sel_ebuf && result_ready_i) begin
            empty_d[ebuf_id] = 1'b0;
        end
        if (empty_valid_i && !(sel_empty && result_ready_i)) begin
            empty_d[empty_id_i] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            empty_q     <= '0;
            csr_valid_q <= 1'b0;
            hold_q      <= 1'b0;
        end else begin
            empty_q <= empty_d;
            hold_q  <= result_valid_o & ~result_ready_i;
            if (csr_valid_i && csr_ready_o) begin
                csr_valid_q <= 1'b1;
            end else if (sel_csr && result_ready_i) begin
                csr_valid_q <= 1'b0;
            end
        end
    end

    // An incoming empty that stalls is in the bitmap by the next cycle
    always_ff @(posedge clk_i) begin
        hold_src_q <= {sel_lsu, sel_xreg, sel_csr, sel_ebuf | sel_empty};
        hold_eid_q <= result_id_o;
        if (csr_valid_i && csr_ready_o) begin
            csr_id_q      <= csr_id_i;
            csr_rd_q      <= csr_rd_i;
            csr_delayed_q <= csr_delayed_i;
            csr_data_q    <= csr_data_i;
        end
    end

    always_comb begin
        result_valid_o   = sel_lsu | sel_xreg | sel_csr | sel_ebuf | sel_empty;
        result_id_o      = '0;
        result_payload_o = '0;
        result_rd_o      = '0;
        result_we_o      = 1'b0;
        result_exc_o     = 1'b0;
        if (sel_lsu) begin
            result_id_o                    = lsu_id_i;
            result_exc_o                   = lsu_exc_i;
            result_payload_o.exc.exccode   = lsu_exccode_i;
        end else if (sel_xreg) begin
            result_id_o           = xreg_id_i;
            result_payload_o.data = xreg_data_i;
            result_rd_o           = xreg_rd_i;
            result_we_o           = 1'b1;
        end else if (sel_csr) begin
            result_id_o           = csr_id_q;
            result_payload_o.data = csr_delayed_q ? csr_delayed_data_i : csr_data_q;
            result_rd_o           = csr_rd_q;
            result_we_o           = 1'b1;
        end else if (sel_ebuf) begin
            result_id_o = ebuf_id;
        end else if (sel_empty) begin
            result_id_o = empty_id_i;
        end
    end

    a_payload_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_valid_o && !result_ready_i |=> $stable(result_payload_o));

    // Dispatch never reissues an ID whose empty result is still pending
    a_empty_unique: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        empty_valid_i |-> !empty_q[empty_id_i]);

endmodule

//--- logic/vcop_result_top.sv
/*
 * Result-return path top level: dispatch, the three result producers
 * and the result arbiter
 */
`timescale 1ns/1ps

module vcop_result_top (
    input  logic                      clk_i,
    input  logic                      async_rst_ni,
    input  logic                      issue_valid_i,
    output logic                      issue_ready_o,
    input  logic [vcop_pkg::ID_W-1:0] issue_id_i,
    input  vcop_pkg::op_e             issue_op_i,
    input  logic [31:0]               issue_rs1_i,
    input  logic [4:0]                issue_rd_i,
    output logic                      result_valid_o,
    input  logic                      result_ready_i,
    output logic [vcop_pkg::ID_W-1:0] result_id_o,
    output vcop_pkg::result_payload_u result_payload_o,
    output logic [4:0]                result_rd_o,
    output logic                      result_we_o,
    output logic                      result_exc_o
);

    logic lsu_req_valid, lsu_req_ready, popc_req_valid, popc_req_ready;
    logic csr_req_valid, csr_req_ready, empty_valid, retire;
    logic                      lsu_valid, lsu_ready, lsu_exc;
    logic [vcop_pkg::ID_W-1:0] lsu_id, xreg_id, csr_id;
    logic [5:0]                lsu_exccode;
    logic                      xreg_valid, xreg_ready, csr_valid, csr_ready, csr_delayed;
    logic [4:0]                xreg_rd, csr_rd;
    logic [31:0]               xreg_data, csr_data, csr_delayed_data;

    // A result retires on its transfer
    assign retire = result_valid_o & result_ready_i;

    vcop_dispatch dispatch_i (
        .clk_i, .async_rst_ni, .issue_valid_i, .issue_ready_o, .issue_id_i, .issue_op_i,
        .retire_i (retire), .retire_id_i (result_id_o),
        .lsu_valid_o (lsu_req_valid), .lsu_ready_i (lsu_req_ready),
        .popc_valid_o (popc_req_valid), .popc_ready_i (popc_req_ready),
        .csr_valid_o (csr_req_valid), .csr_ready_i (csr_req_ready),
        .empty_valid_o (empty_valid)
    );

    vcop_lsu_check lsu_check_i (
        .clk_i, .async_rst_ni,
        .req_valid_i (lsu_req_valid), .req_ready_o (lsu_req_ready),
        .req_id_i (issue_id_i), .req_addr_i (issue_rs1_i),
        .res_valid_o (lsu_valid), .res_ready_i (lsu_ready), .res_id_o (lsu_id),
        .res_exc_o (lsu_exc), .res_exccode_o (lsu_exccode)
    );

    vcop_popc_pipe popc_pipe_i (
        .clk_i, .async_rst_ni,
        .req_valid_i (popc_req_valid), .req_ready_o (popc_req_ready),
        .req_id_i (issue_id_i), .req_rd_i (issue_rd_i), .req_src_i (issue_rs1_i),
        .res_valid_o (xreg_valid), .res_ready_i (xreg_ready), .res_id_o (xreg_id),
        .res_rd_o (xreg_rd), .res_data_o (xreg_data)
    );

    vcop_csr_unit csr_unit_i (
        .clk_i, .async_rst_ni,
        .req_valid_i (csr_req_valid), .req_ready_o (csr_req_ready), .req_id_i (issue_id_i),
        .req_rd_i (issue_rd_i), .req_op_i (issue_op_i), .req_src_i (issue_rs1_i),
        .retire_i (retire),
        .res_valid_o (csr_valid), .res_ready_i (csr_ready), .res_id_o (csr_id),
        .res_rd_o (csr_rd), .res_delayed_o (csr_delayed), .res_data_o (csr_data),
        .res_delayed_data_o (csr_delayed_data)
    );

    vcop_result_arbiter result_arbiter_i (
        .clk_i, .async_rst_ni,
        .empty_valid_i (empty_valid), .empty_id_i (issue_id_i),
        .lsu_valid_i (lsu_valid), .lsu_ready_o (lsu_ready), .lsu_id_i (lsu_id),
        .lsu_exc_i (lsu_exc), .lsu_exccode_i (lsu_exccode),
        .xreg_valid_i (xreg_valid), .xreg_ready_o (xreg_ready), .xreg_id_i (xreg_id),
        .xreg_rd_i (xreg_rd), .xreg_data_i (xreg_data),
        .csr_valid_i (csr_valid), .csr_ready_o (csr_ready), .csr_id_i (csr_id),
        .csr_rd_i (csr_rd), .csr_delayed_i (csr_delayed), .csr_data_i (csr_data),
        .csr_delayed_data_i (csr_delayed_data),
        .result_valid_o, .result_ready_i, .result_id_o, .result_payload_o,
        .result_rd_o, .result_we_o, .result_exc_o
    );

endmodule

//--- vcop_result_top.f
logic/vcop_pkg.sv
logic/vcop_dispatch.sv
logic/vcop_lsu_check.sv
logic/vcop_popc_pipe.sv
logic/vcop_csr_unit.sv
logic/vcop_result_arbiter.sv
logic/vcop_result_top.sv
verif/tb_clock_gen.sv
verif/tb_vcop_result.sv

//--- verif/tb_clock_gen.sv
/*
 * Testbench clock and reset: 20 ns clock, active-low reset for 3 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic async_rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        async_rst_no = 1'b0;
        repeat (3) @(negedge clk_o);
        async_rst_no = 1'b1;
    end

endmodule

//--- verif/tb_vcop_result.sv
/*
 * Testbench for the result-return path driving a random issue stream and
 * result back-pressure, checked by assertions against a per-ID scoreboard
 */
`timescale 1ns/1ps

module tb_vcop_result;

    localparam int unsigned NUM_INSTR = 400;
    localparam int unsigned TIMEOUT   = 200;
    localparam logic [31:0] SEED      = 32'h8679_6fd1;

    logic                      clk_i;
    logic                      async_rst_ni;
    logic                      issue_valid_i;
    logic                      issue_ready_o;
    logic [vcop_pkg::ID_W-1:0] issue_id_i;
    vcop_pkg::op_e             issue_op_i;
    logic [31:0]               issue_rs1_i;
    logic [4:0]                issue_rd_i;
    logic                      result_valid_o;
    logic                      result_ready_i;
    logic [vcop_pkg::ID_W-1:0] result_id_o;
    vcop_pkg::result_payload_u result_payload_o;
    logic [4:0]                result_rd_o;
    logic                      result_we_o;
    logic                      result_exc_o;

    // Scoreboard with one entry per ID
    vcop_pkg::op_e               sb_op [vcop_pkg::ID_CNT];
    logic [31:0]                 sb_rs1 [vcop_pkg::ID_CNT];
    logic [4:0]                  sb_rd [vcop_pkg::ID_CNT];
    logic [31:0]                 sb_vl [vcop_pkg::ID_CNT];
    logic [vcop_pkg::ID_CNT-1:0] sb_inflight;
    logic [31:0]                 model_vl;
    logic [31:0]                 issue_count;
    logic [31:0]                 retire_count;

    logic          issue_fire, result_fire, same_cycle;
    vcop_pkg::op_e exp_op;
    logic [31:0]   exp_rs1, exp_popc;
    logic [4:0]    exp_rd;

    tb_clock_gen clock_gen_i (
        .clk_o        (clk_i),
        .async_rst_no (async_rst_ni)
    );

    vcop_result_top dut_i (.*);

    function automatic logic [31:0] count_ones(input logic [31:0] v);
        logic [31:0] rest;
        logic [31:0] n;
        rest = v;
        n    = '0;
        while (rest != 32'd0) begin
            rest = rest & (rest - 32'd1);
            n    = n + 32'd1;
        end
        return n;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    // An empty result can leave in the cycle its instruction is issued
    always_comb begin
        issue_fire  = issue_valid_i & issue_ready_o;
        result_fire = result_valid_o & result_ready_i;
        same_cycle  = issue_fire && issue_op_i == vcop_pkg::OP_EMPTY
                   && (issue_id_i == result_id_o);
        exp_op      = same_cycle ? issue_op_i : sb_op[result_id_o];
        exp_rs1     = same_cycle ? issue_rs1_i : sb_rs1[result_id_o];
        exp_rd      = same_cycle ? issue_rd_i : sb_rd[result_id_o];
        exp_popc    = count_ones(exp_rs1);
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            sb_inflight  <= '0;
            model_vl     <= '0;
            issue_count  <= '0;
            retire_count <= '0;
        end else begin
            if (issue_fire) begin
                sb_op[issue_id_i]       <= issue_op_i;
                sb_rs1[issue_id_i]      <= issue_rs1_i;
                sb_rd[issue_id_i]       <= issue_rd_i;
                sb_vl[issue_id_i]       <= model_vl;
                sb_inflight[issue_id_i] <= 1'b1;
                issue_count             <= issue_count + 32'd1;
                if (issue_op_i == vcop_pkg::OP_CSRRW_VL) begin
                    model_vl <= issue_rs1_i;
                end
            end
            if (result_fire) begin
                sb_inflight[result_id_o] <= 1'b0;
                retire_count             <= retire_count + 32'd1;
            end
        end
    end

    a_known_id: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire |-> (sb_inflight[result_id_o] || same_cycle))
        else stop_with_error($sformatf("[FAIL] %0t result for an ID not in flight", $time));

    a_empty: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_EMPTY |-> !result_we_o && !result_exc_o)
        else stop_with_error($sformatf("[FAIL] %0t empty result with we or exc set", $time));

    a_load: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_LOAD
        |-> !result_we_o && (result_exc_o == (exp_rs1[1:0] != 2'b00)))
        else stop_with_error($sformatf("[FAIL] %0t wrong load exception flag", $time));

    a_load_code: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_LOAD && result_exc_o
        |-> result_payload_o.exc.exccode == vcop_pkg::EXC_LOAD_MISALIGNED)
        else stop_with_error($sformatf("[FAIL] %0t wrong load exception code", $time));

    a_popc: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_POPC
        |-> result_we_o && result_rd_o == exp_rd && result_payload_o.data == exp_popc)
        else stop_with_error($sformatf("[FAIL] %0t wrong popcount result", $time));

    a_vl_swap: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_CSRRW_VL
        |-> result_we_o && result_rd_o == exp_rd
            && result_payload_o.data == sb_vl[result_id_o])
        else stop_with_error($sformatf("[FAIL] %0t wrong vector length returned", $time));

    a_retired: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_fire && exp_op == vcop_pkg::OP_CSRR_RETIRED
        |-> result_we_o && result_rd_o == exp_rd && result_payload_o.data == retire_count)
        else stop_with_error($sformatf("[FAIL] %0t wrong retired count", $time));

    a_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        result_valid_o && !result_ready_i
        |=> result_valid_o && $stable(result_id_o) && $stable(result_payload_o)
            && $stable(result_rd_o) && $stable(result_we_o) && $stable(result_exc_o))
        else stop_with_error($sformatf("[FAIL] %0t result changed while stalled", $time));

    a_busy_id: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        issue_valid_i && sb_inflight[issue_id_i] |-> !issue_ready_o)
        else stop_with_error($sformatf("[FAIL] %0t issue ready for an ID in flight", $time));

    task automatic wait_reset_release();
        int unsigned waited;
        waited = 0;
        while (!async_rst_ni) begin
            if (waited >= TIMEOUT) begin
                stop_with_error("reset was never released");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        @(negedge clk_i);
    endtask

    // Called on a falling edge and returns on the falling edge after the transfer
    task automatic issue_random();
        logic [31:0] start;
        logic [31:0] rnd;
        logic [31:0] op_sel;
        int unsigned waited;
        start         = issue_count;
        rnd           = $urandom;
        op_sel        = rnd % 32'd5;
        issue_id_i    = rnd[8 +: vcop_pkg::ID_W];
        issue_rd_i    = rnd[20:16];
        issue_op_i    = vcop_pkg::op_e'(op_sel[2:0]);
        issue_rs1_i   = $urandom;
        issue_valid_i = 1'b1;
        waited        = 0;
        @(negedge clk_i);
        while (issue_count == start) begin
            if (waited >= TIMEOUT) begin
                stop_with_error("issue was not accepted before the timeout");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        issue_valid_i = 1'b0;
    endtask

    task automatic wait_all_retired();
        int unsigned waited;
        waited = 0;
        while (retire_count != issue_count) begin
            if (waited >= TIMEOUT) begin
                stop_with_error("outstanding results did not return before the timeout");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
    endtask

    initial begin : stimulus
        logic [31:0] gap;
        issue_valid_i = 1'b0;
        issue_id_i    = '0;
        issue_op_i    = vcop_pkg::OP_EMPTY;
        issue_rs1_i   = '0;
        issue_rd_i    = '0;
        void'($urandom(SEED));
        wait_reset_release();
        for (int n = 0; n < NUM_INSTR; n++) begin
            issue_random();
            gap = $urandom % 32'd3;
            repeat (gap) @(negedge clk_i);
        end
        wait_all_retired();
        if (result_valid_o) begin
            stop_with_error("a result is still offered after all results retired");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

    // Random back-pressure with occasional long stalls to fill the bitmap
    initial begin : back_pressure
        logic [31:0] rnd;
        result_ready_i = 1'b0;
        forever begin
            @(negedge clk_i);
            rnd = $urandom;
            if (rnd[7:4] == 4'd0) begin
                result_ready_i = 1'b0;
                repeat (6) @(negedge clk_i);
            end else begin
                result_ready_i = (rnd[2:0] < 3'd5);
            end
        end
    end

endmodule
